// File: hdl/vio_pkg.sv
package vio_pkg;

    // ###################################################################
    // UART register map.
    // ###################################################################

    // Offsets within the UART window, taken from wbs_adr_i[2:0].
    localparam logic [2:0] REG_RBR_THR = 3'd0;  // RBR on read, THR on write.
    localparam logic [2:0] REG_IER     = 3'd1;  // Interrupt enable.
    localparam logic [2:0] REG_IIR     = 3'd2;  // Interrupt identification, read only.
    localparam logic [2:0] REG_LCR     = 3'd3;  // Line control.
    localparam logic [2:0] REG_LSR     = 3'd5;  // Line status, read only.
    // While DLAB is set, offsets 0 and 1 reach DLL and DLM instead.

    localparam int LCR_DLAB = 7;  // Divisor latch access bit.

    // Line status bit positions.
    localparam int LSR_DR   = 0;  // Receive FIFO holds at least one entry.
    localparam int LSR_OE   = 1;  // A frame was lost to a full receive FIFO.
    localparam int LSR_FE   = 3;  // Head entry of the receive FIFO had a bad stop bit.
    localparam int LSR_THRE = 5;  // Transmit FIFO is empty.
    localparam int LSR_TEMT = 6;  // Transmit FIFO empty and the shifter idle.

    // Interrupt enable bit positions.
    localparam int IER_ERBFI = 0;  // Received data available.
    localparam int IER_ETBEI = 1;  // Transmit holding register empty.

    // Interrupt identification codes, highest priority first.
    localparam logic [7:0] IIR_RDA  = 8'h04;
    localparam logic [7:0] IIR_THRE = 8'h02;
    localparam logic [7:0] IIR_NONE = 8'h01;  // Bit 0 set means nothing pending.

    localparam int OVERSAMPLE = 16;  // Ticks per serial bit.

    // One receive FIFO entry. The framing flag travels with its byte.
    typedef struct packed {
        logic [7:0] data;
        logic       fe;
    } rx_entry_t;

    // ###################################################################
    // Byte lane helpers for the 32-bit bus.
    // ###################################################################

    // Merges every selected lane into one byte.
    function automatic logic [7:0] tobyte(input logic [3:0] sel, input logic [31:0] dat);
        return ({8{sel[3]}} & dat[31:24]) | ({8{sel[2]}} & dat[23:16]) |
               ({8{sel[1]}} & dat[15:8])  | ({8{sel[0]}} & dat[7:0]);
    endfunction

    // Copies a byte onto all four lanes so any lane select reads it.
    function automatic logic [31:0] toword(input logic [7:0] dat);
        return {4{dat}};
    endfunction

endpackage

// File: hdl/vio_fifo.sv
module vio_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic     wbs_clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,   // Write data_i at the tail.
    input  payload_t data_i,
    input  logic     pop_i,    // Drop the head entry.
    output payload_t data_o,   // Head entry, valid whenever empty_o is low.
    output logic     empty_o,
    output logic     full_o
);

    localparam int AW = $clog2(FIFO_DEPTH);  // Depth is a power of two.

    payload_t    mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;  // The extra top bit tells full from empty.
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    // Pushes into a full buffer and pops from an empty one are ignored.
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Equal pointers mean empty; same index with differing wrap bits means full.
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign data_o = mem[rd_ptr[AW-1:0]];  // Show-ahead read of the head.

    always_ff @(posedge wbs_clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // The wrap bit toggles on overflow.
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage array.
    always_ff @(posedge wbs_clk_i)
    begin
        if (do_push)
            mem[wr_ptr[AW-1:0]] <= data_i;
    end

endmodule

// File: hdl/uart_tx.sv
module uart_tx (
    input  logic       wbs_clk_i,
    input  logic       rst_n_i,
    input  logic       tick_i,        // Oversampling tick, 16 per bit.
    input  logic       fifo_empty_i,
    input  logic [7:0] fifo_data_i,   // Head of the transmit FIFO.
    output logic       fifo_pop_o,
    output logic       busy_o,
    output logic       tx_o
);
    import vio_pkg::*;

    localparam int TW        = $clog2(OVERSAMPLE);
    localparam int FRAME_LEN = 10;  // Start, eight data bits, stop.

    logic                 busy_q;
    logic [FRAME_LEN-1:0] frame_q;   // Bit 0 is always the level on the line.
    logic [TW-1:0]        tick_cnt;  // Ticks spent in the current bit.
    logic [3:0]           bit_cnt;   // Index of the bit on the line.

    // A new byte is taken as soon as the shifter is free.
    assign fifo_pop_o = !busy_q && !fifo_empty_i;

    // ###################################################################
    // Frame shifter.
    // ###################################################################

    always_ff @(posedge wbs_clk_i)
    begin
        if (!rst_n_i)
        begin
            busy_q   <= 1'b0;
            frame_q  <= '1;  // Line idles high.
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (fifo_pop_o)
        begin
            // Stop bit on top, start bit at the bottom, data LSB first.
            busy_q   <= 1'b1;
            frame_q  <= {1'b1, fifo_data_i, 1'b0};
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (busy_q && tick_i)
        begin
            if (tick_cnt == TW'(OVERSAMPLE - 1))
            begin
                tick_cnt <= '0;
                if (bit_cnt == 4'(FRAME_LEN - 1))
                    busy_q <= 1'b0;  // Stop bit finished, the line stays high.
                else
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    frame_q <= {1'b1, frame_q[FRAME_LEN-1:1]};  // Next bit, fill with idle.
                end
            end
            else
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign busy_o = busy_q;      // High from the pop until the stop bit ends.
    assign tx_o   = frame_q[0];

endmodule

// File: hdl/uart_rx.sv
module uart_rx (
    input  logic               wbs_clk_i,
    input  logic               rst_n_i,
    input  logic               tick_i,    // Oversampling tick, 16 per bit.
    input  logic               rx_i,      // Asynchronous serial input.
    output logic               push_o,    // One-cycle strobe with a finished entry.
    output vio_pkg::rx_entry_t entry_o
);
    import vio_pkg::*;

    localparam int TW = $clog2(OVERSAMPLE);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t     state_q;
    logic          rx_meta;    // First synchronizer stage.
    logic          rx_sync;    // Second stage, safe to use.
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift_q;    // Data bits arrive LSB first.
    logic          mid_start;  // Halfway into the start bit.
    logic          mid_bit;    // One full bit after the previous sample point.

    assign mid_start = tick_i && (tick_cnt == TW'(OVERSAMPLE / 2 - 1));
    assign mid_bit   = tick_i && (tick_cnt == TW'(OVERSAMPLE - 1));

    // Two flops bring rx into the clock domain. Both reset to the idle level.
    always_ff @(posedge wbs_clk_i)
    begin
        if (!rst_n_i)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    // ###################################################################
    // Frame FSM.
    // ###################################################################

    always_ff @(posedge wbs_clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q  <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            push_o   <= 1'b0;
        end
        else
        begin
            push_o <= 1'b0;
            if (tick_i)
                tick_cnt <= tick_cnt + 1'b1;  // Wraps at 16 by width.
            case (state_q)
                RX_IDLE:
                begin
                    tick_cnt <= '0;
                    if (!rx_sync)
                        state_q <= RX_START;  // Falling edge, maybe a start bit.
                end
                RX_START:
                    if (mid_start)
                    begin
                        tick_cnt <= '0;  // Later samples land at mid-bit.
                        bit_cnt  <= '0;
                        state_q  <= rx_sync ? RX_IDLE : RX_DATA;  // High again is a glitch.
                    end
                RX_DATA:
                    if (mid_bit)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state_q <= RX_STOP;
                    end
                RX_STOP:
                    if (mid_bit)
                    begin
                        push_o  <= 1'b1;  // The entry is handed over even with a bad stop.
                        state_q <= RX_IDLE;
                    end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data path of the frame.
    always_ff @(posedge wbs_clk_i)
    begin
        if (state_q == RX_DATA && mid_bit)
            shift_q <= {rx_sync, shift_q[7:1]};
        if (state_q == RX_STOP && mid_bit)
        begin
            entry_o.data <= shift_q;
            entry_o.fe   <= !rx_sync;  // A low stop bit is a framing error.
        end
    end

endmodule

// File: hdl/uart16750_wb.sv
module uart16750_wb #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       wb_clk_i,
    input  logic       rst_n_i,
    input  logic [7:0] wbs_dat_i,
    input  logic [2:0] wbs_adr_i,
    input  logic       wbs_we_i,
    input  logic       wbs_stb_i,
    input  logic       wbs_cyc_i,   // Already qualified by the chip select.
    output logic [7:0] wbs_dat_o,
    output logic       wbs_ack_o,
    input  logic       rx_i,
    output logic       tx_o,
    output logic       irq_o
);
    import vio_pkg::*;

    logic        ack_q;
    logic [1:0]  ier_q;      // ERBFI and ETBEI only.
    logic        dlab_q;
    logic [7:0]  dll_q;
    logic [7:0]  dlm_q;
    logic        oe_q;
    logic [15:0] tick_cnt;
    logic [15:0] div_last;   // Last count of a tick period.
    logic        tick;
    logic        acc;        // Ack cycle of a live request.
    logic        wr_acc;
    logic        rd_acc;
    logic        thr_wr;
    logic        rbr_rd;
    logic        lsr_rd;
    logic [7:0]  lsr;
    logic [7:0]  iir;
    logic [7:0]  rd_data;
    logic        tx_empty, tx_full, tx_pop, tx_busy;
    logic [7:0]  tx_data;
    logic        rx_push, rx_empty, rx_full;
    rx_entry_t   rx_entry, rx_head;

    // ###################################################################
    // Bus handshake and access strobes.
    // ###################################################################

    // Ack one cycle after the request, never twice in a row.
    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
            ack_q <= 1'b0;
        else
            ack_q <= wbs_cyc_i && wbs_stb_i && !ack_q;
    end

    assign acc    = ack_q && wbs_cyc_i && wbs_stb_i;  // Side effects land at the ack edge.
    assign wr_acc = acc && wbs_we_i;
    assign rd_acc = acc && !wbs_we_i;
    assign thr_wr = wr_acc && (wbs_adr_i == REG_RBR_THR) && !dlab_q && !tx_full;
    assign rbr_rd = rd_acc && (wbs_adr_i == REG_RBR_THR) && !dlab_q;
    assign lsr_rd = rd_acc && (wbs_adr_i == REG_LSR);

    // Writable registers. The divisor comes out of reset as 1.
    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
        begin
            ier_q  <= '0;
            dlab_q <= 1'b0;
            dll_q  <= 8'd1;
            dlm_q  <= 8'd0;
        end
        else if (wr_acc)
        begin
            case (wbs_adr_i)
                REG_RBR_THR: if (dlab_q) dll_q <= wbs_dat_i;  // THR goes to the FIFO.
                REG_IER:
                    if (dlab_q)
                        dlm_q <= wbs_dat_i;
                    else
                    begin
                        ier_q[IER_ERBFI] <= wbs_dat_i[IER_ERBFI];
                        ier_q[IER_ETBEI] <= wbs_dat_i[IER_ETBEI];
                    end
                REG_LCR: dlab_q <= wbs_dat_i[LCR_DLAB];
                default: ;  // IIR and LSR are read only.
            endcase
        end
    end

    // Overrun sticks until LSR is read. A new overrun wins over the clear.
    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
            oe_q <= 1'b0;
        else if (rx_push && rx_full)
            oe_q <= 1'b1;
        else if (lsr_rd)
            oe_q <= 1'b0;
    end

    // ###################################################################
    // Baud tick, one pulse every divisor clocks.
    // ###################################################################

    assign div_last = ({dlm_q, dll_q} == 16'd0) ? 16'd0 : {dlm_q, dll_q} - 16'd1;
    assign tick     = (tick_cnt >= div_last);  // Also recovers when the divisor shrinks.

    always_ff @(posedge wb_clk_i)
    begin
        if (!rst_n_i)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 16'd1;
    end

    // ###################################################################
    // FIFOs and serial engines.
    // ###################################################################

    vio_fifo #(.payload_t(logic [7:0]), .FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .wbs_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
        .push_i(thr_wr), .data_i(wbs_dat_i),
        .pop_i(tx_pop), .data_o(tx_data),
        .empty_o(tx_empty), .full_o(tx_full)
    );

    vio_fifo #(.payload_t(rx_entry_t), .FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .wbs_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
        .push_i(rx_push), .data_i(rx_entry),  // Dropped when full, see oe_q.
        .pop_i(rbr_rd), .data_o(rx_head),
        .empty_o(rx_empty), .full_o(rx_full)
    );

    uart_tx tx_inst (
        .wbs_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .tick_i(tick),
        .fifo_empty_i(tx_empty), .fifo_data_i(tx_data), .fifo_pop_o(tx_pop),
        .busy_o(tx_busy), .tx_o(tx_o)
    );

    uart_rx rx_inst (
        .wbs_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .tick_i(tick),
        .rx_i(rx_i), .push_o(rx_push), .entry_o(rx_entry)
    );

    // ###################################################################
    // Status, interrupt and read data.
    // ###################################################################

    always_comb
    begin
        lsr           = '0;
        lsr[LSR_DR]   = !rx_empty;
        lsr[LSR_OE]   = oe_q;
        lsr[LSR_FE]   = !rx_empty && rx_head.fe;  // Describes the byte RBR would return.
        lsr[LSR_THRE] = tx_empty;
        lsr[LSR_TEMT] = tx_empty && !tx_busy;
    end

    // Received data outranks an empty transmitter.
    always_comb
    begin
        if (ier_q[IER_ERBFI] && !rx_empty)
            iir = IIR_RDA;
        else if (ier_q[IER_ETBEI] && tx_empty)
            iir = IIR_THRE;
        else
            iir = IIR_NONE;
    end

    assign irq_o = (ier_q[IER_ERBFI] && !rx_empty) || (ier_q[IER_ETBEI] && tx_empty);

    always_comb
    begin
        rd_data = '0;
        case (wbs_adr_i)
            REG_RBR_THR: rd_data = dlab_q ? dll_q : (rx_empty ? 8'h00 : rx_head.data);
            REG_IER:     rd_data = dlab_q ? dlm_q : {6'b0, ier_q};
            REG_IIR:     rd_data = iir;
            REG_LCR:     rd_data[LCR_DLAB] = dlab_q;
            REG_LSR:     rd_data = lsr;
            default:     rd_data = '0;
        endcase
    end

    assign wbs_dat_o = rd_data;  // The top level masks it with ack.
    assign wbs_ack_o = ack_q;

endmodule

// File: hdl/versatile_io.sv
module versatile_io #(
    parameter logic [31:0] BASE_ADR   = 32'h9000_0000,
    parameter int          MAP_HI     = 31,
    parameter int          MAP_LO     = 3,
    parameter int          FIFO_DEPTH = 16
) (
    input  logic        wbs_clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] wbs_dat_i,
    input  logic [31:0] wbs_adr_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic        wbs_we_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_cyc_i,
    output logic [31:0] wbs_dat_o,
    output logic        wbs_ack_o,
    input  logic        uart0_rx_pad_i,
    output logic        uart0_tx_pad_o,
    output logic        uart0_irq_o
);
    import vio_pkg::*;

    logic       uart0_cs;
    logic [7:0] uart0_dat;
    logic       uart0_ack;

    // ###################################################################
    // Address window of the UART.
    // ###################################################################

    // Only the bits between MAP_HI and MAP_LO are compared.
    assign uart0_cs = (wbs_adr_i[MAP_HI:MAP_LO] == BASE_ADR[MAP_HI:MAP_LO]);

    // The UART only sees a cycle when the window matches, so other addresses never ack.
    uart16750_wb #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart0 (
        .wb_clk_i  (wbs_clk_i),
        .rst_n_i   (rst_n_i),
        .wbs_dat_i (tobyte(wbs_sel_i, wbs_dat_i)),  // Whichever lanes are selected.
        .wbs_adr_i (wbs_adr_i[2:0]),
        .wbs_we_i  (wbs_we_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i && uart0_cs),
        .wbs_dat_o (uart0_dat),
        .wbs_ack_o (uart0_ack),
        .rx_i      (uart0_rx_pad_i),
        .tx_o      (uart0_tx_pad_o),
        .irq_o     (uart0_irq_o)
    );

    // The byte is returned on all lanes and the bus stays at zero outside the ack.
    assign wbs_dat_o = toword(uart0_dat) & {32{uart0_ack}};
    assign wbs_ack_o = uart0_ack;

endmodule

// File: tb/versatile_io_props.sv
module versatile_io_props (
    input logic        wbs_clk_i,
    input logic        rst_n_i,
    input logic        wbs_cyc_i,
    input logic        wbs_stb_i,
    input logic        uart0_cs_i,
    input logic        wbs_ack_o,
    input logic [31:0] wbs_dat_o,
    input logic        uart0_tx_pad_o
);

    // ###################################################################
    // Bus handshake.
    // ###################################################################

    // A held request is acked once, so ack is a single-cycle pulse.
    ack_pulse: assert property (@(posedge wbs_clk_i) disable iff (!rst_n_i)
        wbs_ack_o |=> !wbs_ack_o)
        else $error("ack stayed high for two cycles");

    // Every ack answers a request that hit the window one cycle earlier.
    ack_selected: assert property (@(posedge wbs_clk_i) disable iff (!rst_n_i)
        wbs_ack_o |-> $past(wbs_cyc_i && wbs_stb_i && uart0_cs_i))
        else $error("ack without a selected request");

    // Read data is masked outside the ack cycle.
    dat_masked: assert property (@(posedge wbs_clk_i) disable iff (!rst_n_i)
        !wbs_ack_o |-> (wbs_dat_o == 32'h0))
        else $error("read data not zero while ack is low");

    // ###################################################################
    // Serial line.
    // ###################################################################

    tx_idle_reset: assert property (@(posedge wbs_clk_i)
        !rst_n_i |=> uart0_tx_pad_o)  // Line idles high from reset.
        else $error("tx line low during reset");

endmodule

// File: tb/versatile_io_tb.sv
module versatile_io_tb;
    import vio_pkg::*;

    localparam logic [31:0] BASE       = 32'h9000_0000;
    localparam int          FIFO_DEPTH = 16;  // Entries in each UART FIFO.

    logic        clk, rst_n, we, stb, cyc, rx, tx, irq, ack;
    logic [31:0] dat_i, adr, dat_o;
    logic [3:0]  sel;
    int          errors = 0;
    int          div_val = 1;          // Divisor the serial models run at.
    logic [7:0]  tx_exp[$], tx_got[$]; // Transmit model and decoded bytes.
    logic [7:0]  rx_exp[$];            // Bytes the receive FIFO should hold.
    logic [7:0]  mon_byte, rd, b;
    int          i, n;
    logic        ok;

    versatile_io versatile_io_inst (
        .wbs_clk_i(clk), .rst_n_i(rst_n), .wbs_dat_i(dat_i), .wbs_adr_i(adr),
        .wbs_sel_i(sel), .wbs_we_i(we), .wbs_stb_i(stb), .wbs_cyc_i(cyc),
        .wbs_dat_o(dat_o), .wbs_ack_o(ack), .uart0_rx_pad_i(rx),
        .uart0_tx_pad_o(tx), .uart0_irq_o(irq)
    );

    bind versatile_io versatile_io_props props_inst (
        .wbs_clk_i(wbs_clk_i), .rst_n_i(rst_n_i), .wbs_cyc_i(wbs_cyc_i),
        .wbs_stb_i(wbs_stb_i), .uart0_cs_i(uart0_cs), .wbs_ack_o(wbs_ack_o),
        .wbs_dat_o(wbs_dat_o), .uart0_tx_pad_o(uart0_tx_pad_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // One classic cycle. The byte rides on a random lane; other lanes carry junk.
    task automatic bus_access(input logic wr, input logic [2:0] off, input logic [7:0] wdat,
                              output logic [31:0] rword);
        int   lane;
        int   cnt;
        logic acked;
        logic [31:0] word;
        lane  = $urandom_range(3);
        acked = 1'b0;
        word  = '0;
        @(posedge clk);
        #2;
        adr   = BASE | 32'(off);
        sel   = 4'b0001 << lane;
        dat_i = ($urandom() & ~(32'hff << (8 * lane))) | (32'(wdat) << (8 * lane));
        we    = wr;
        cyc   = 1'b1;
        stb   = 1'b1;
        for (cnt = 0; cnt < 100 && !acked; cnt++)
        begin
            @(negedge clk);
            if (ack)
            begin
                acked = 1'b1;
                word  = dat_o;  // Stable mid-cycle.
            end
        end
        assert (acked)
        else
        begin
            errors++;
            $display("no ack from the DUT for offset %0d", off);
        end
        @(posedge clk);  // The write lands on this edge.
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        rword = word;
    endtask

    task automatic wb_write(input logic [2:0] off, input logic [7:0] d);
        logic [31:0] unused;
        bus_access(1'b1, off, d, unused);
    endtask

    task automatic wb_read(input logic [2:0] off, output logic [7:0] d);
        logic [31:0] word;
        bus_access(1'b0, off, 8'h00, word);
        d = word[7:0];
    endtask

    // The expected byte must come back on all four lanes.
    task automatic read_expect(input string name, input logic [2:0] off, input logic [7:0] exp);
        logic [31:0] word;
        bus_access(1'b0, off, 8'h00, word);
        check_value({"wbs_dat_o ", name}, word, {4{exp}});
    endtask

    // Holds rx for a number of ticks, ticks being div_val clocks.
    task automatic hold_rx(input logic level, input int ticks);
        rx = level;
        repeat (ticks * div_val) @(posedge clk);
        #2;
    endtask

    // A broken stop is low past mid-bit, then high again before a new start could confirm.
    task automatic send_frame(input logic [7:0] d, input logic stop_ok);
        int k;
        @(posedge clk);
        #2;
        hold_rx(1'b0, OVERSAMPLE);
        for (k = 0; k < 8; k++)
            hold_rx(d[k], OVERSAMPLE);
        if (stop_ok)
            hold_rx(1'b1, 2 * OVERSAMPLE);
        else
        begin
            hold_rx(1'b0, 10);
            hold_rx(1'b1, 22);
        end
    endtask

    // Polls LSR until data is ready.
    task automatic wait_data();
        logic [7:0] s;
        int cnt;
        s = '0;
        for (cnt = 0; cnt < 50 && !s[LSR_DR]; cnt++)
            wb_read(REG_LSR, s);
        assert (s[LSR_DR])
        else
        begin
            errors++;
            $display("receive FIFO never reported data ready");
        end
    endtask

    // ###################################################################
    // Serial monitor, samples mid-bit at the programmed bit time.
    // ###################################################################

    always
    begin
        @(negedge tx);
        repeat (8 * div_val) @(negedge clk);
        assert (tx === 1'b0)
        else
        begin
            errors++;
            $display("start bit on the tx line did not hold low");
        end
        for (int k = 0; k < 8; k++)
        begin
            repeat (OVERSAMPLE * div_val) @(negedge clk);
            mon_byte[k] = tx;
        end
        repeat (OVERSAMPLE * div_val) @(negedge clk);
        assert (tx === 1'b1)
        else
        begin
            errors++;
            $display("stop bit on the tx line was not high");
        end
        tx_got.push_back(mon_byte);
    end

    initial
    begin
        void'($urandom(96));
        rst_n = 1'b0;
        rx    = 1'b1;
        we    = 1'b0;
        stb   = 1'b0;
        cyc   = 1'b0;
        dat_i = '0;
        adr   = '0;
        sel   = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // 1. Divisor latch and register readback.
        wb_write(REG_LCR, 8'h80);
        b = 8'($urandom());
        wb_write(REG_IER, b);  // DLM.
        read_expect("dlm", REG_IER, b);
        wb_write(REG_IER, 8'h00);
        div_val = $urandom_range(3, 1);
        wb_write(REG_RBR_THR, 8'(div_val));  // DLL.
        read_expect("dll", REG_RBR_THR, 8'(div_val));
        read_expect("lcr", REG_LCR, 8'h80);
        wb_write(REG_LCR, 8'h00);
        read_expect("lcr", REG_LCR, 8'h00);
        b = 8'($urandom());
        wb_write(REG_IER, b);
        read_expect("ier", REG_IER, b & 8'h03);  // Only two enables exist.
        wb_write(REG_IER, 8'h00);

        // 2. Transmit 20 bytes, never more than 15 ahead of the monitor.
        for (i = 0; i < 20; i++)
        begin
            for (n = 0; n < 5000 && (tx_exp.size() - tx_got.size()) >= 15; n++)
                @(posedge clk);
            b = 8'($urandom());
            tx_exp.push_back(b);
            wb_write(REG_RBR_THR, b);
        end
        for (n = 0; n < 20000 && tx_got.size() < 20; n++)
            @(posedge clk);
        check_value("uart0_tx_pad_o frame count", tx_got.size(), 20);
        for (i = 0; i < 20 && i < tx_got.size(); i++)
            check_value("uart0_tx_pad_o byte", {24'h0, tx_got[i]}, {24'h0, tx_exp[i]});
        rd = '0;
        for (n = 0; n < 50 && !rd[LSR_TEMT]; n++)
            wb_read(REG_LSR, rd);
        check_value("lsr after tx", {24'h0, rd}, 32'h60);

        // 3. Receive with random good or broken stop bits.
        for (i = 0; i < 8; i++)
        begin
            b  = 8'($urandom());
            ok = ($urandom_range(3) != 0);
            send_frame(b, ok);
            wait_data();
            read_expect("lsr rx", REG_LSR, 8'h61 | (ok ? 8'h00 : 8'h08));
            read_expect("rbr", REG_RBR_THR, b);
        end

        // 4. Overrun: 17 frames, the last one is lost.
        for (i = 0; i < 17; i++)
        begin
            b = 8'($urandom());
            if (i < FIFO_DEPTH)
                rx_exp.push_back(b);
            send_frame(b, 1'b1);
        end
        read_expect("lsr overrun", REG_LSR, 8'h63);
        read_expect("lsr oe cleared", REG_LSR, 8'h61);
        while (rx_exp.size() > 0)
            read_expect("rbr after overrun", REG_RBR_THR, rx_exp.pop_front());
        read_expect("lsr drained", REG_LSR, 8'h60);
        read_expect("rbr empty", REG_RBR_THR, 8'h00);

        // 5. Interrupts.
        wb_write(REG_IER, 8'h01);
        @(negedge clk);
        check_value("uart0_irq_o", irq, 1'b0);
        read_expect("iir", REG_IIR, IIR_NONE);
        b = 8'($urandom());
        send_frame(b, 1'b1);
        wait_data();
        @(negedge clk);
        check_value("uart0_irq_o", irq, 1'b1);
        read_expect("iir", REG_IIR, IIR_RDA);
        read_expect("rbr irq", REG_RBR_THR, b);
        @(negedge clk);
        check_value("uart0_irq_o", irq, 1'b0);
        wb_write(REG_IER, 8'h02);
        @(negedge clk);
        check_value("uart0_irq_o", irq, 1'b1);
        read_expect("iir", REG_IIR, IIR_THRE);
        wb_write(REG_IER, 8'h00);
        @(negedge clk);
        check_value("uart0_irq_o", irq, 1'b0);
        read_expect("iir", REG_IIR, IIR_NONE);

        // 6. Out-of-window access must never be acked.
        @(posedge clk);
        #2;
        adr = 32'h1000_0000;
        sel = 4'b0001;
        cyc = 1'b1;
        stb = 1'b1;
        ok  = 1'b0;
        for (n = 0; n < 50; n++)
        begin
            @(negedge clk);
            if (ack)
                ok = 1'b1;
        end
        assert (!ok)
        else
        begin
            errors++;
            $display("access outside the window was acked");
        end
        @(posedge clk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        read_expect("lcr after decode", REG_LCR, 8'h00);

        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: versatile_io.f
hdl/vio_pkg.sv
hdl/vio_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart16750_wb.sv
hdl/versatile_io.sv
tb/versatile_io_props.sv
tb/versatile_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= versatile_io_tb
FILELIST  ?= versatile_io.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
